/* src/adderPkg.sv */
`default_nettype none

package adderPkg;

	// Datapath widths
	localparam int PRODUCT_W = 16; // One unsigned multiplier product
	localparam int ROW_TAPS  = 24; // Products per row, the tree is built for exactly this
	localparam int ROW_SUM_W = 21; // Holds 24 * 16'hFFFF without overflow
	localparam int HALF_W    = 23; // One half of a partial sum

	typedef logic [PRODUCT_W-1:0] productT;
	typedef logic [ROW_SUM_W-1:0] rowSumT;
	typedef logic [HALF_W-1:0]    halfSumT;

	// Only stride 1 windows are handled
	typedef enum logic {
		WIN3X3 = 1'b0,
		WIN5X5 = 1'b1
	} windowSizeT;

	// Sampled together with the valid of a beat
	typedef struct packed {
		windowSizeT winSize;
		logic       winRound; // Second pass of a 5x5 window
	} convCfgT;

	typedef productT [ROW_TAPS-1:0] rowProductsT;

	// Row 1 sits at index 0
	typedef rowProductsT [2:0] columnProductsT;

	// Front half occupies the upper bits
	typedef struct packed {
		halfSumT front;
		halfSumT back;
	} psumHalvesT;

endpackage

`default_nettype wire

/* src/rowReduceTree.sv */
`timescale 1ns/1ns
`default_nettype none

module rowReduceTree import adderPkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        valid,
	input  rowProductsT row,
	output logic        sumValid,
	output rowSumT      sum
);

	localparam int GROUPS = ROW_TAPS / 3; // Eight three-input adders in the first stage
	localparam int S1_W = PRODUCT_W + 2;  // Three products need two extra bits
	localparam int S2_W = S1_W + 1;
	localparam int S3_W = S2_W + 1;

	logic [GROUPS-1:0][S1_W-1:0]   stage1;
	logic [GROUPS/2-1:0][S2_W-1:0] stage2;
	logic [GROUPS/4-1:0][S3_W-1:0] stage3;
	logic [3:0]                    validPipe;

	// Stage 1 folds the row in groups of three neighbouring taps
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stage1 <= '0;
		end else begin
			for (int g = 0; g < GROUPS; g++) begin
				stage1[g] <= S1_W'(row[3*g]) + S1_W'(row[3*g+1]) + S1_W'(row[3*g+2]);
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stage2 <= '0;
		end else begin
			for (int p = 0; p < GROUPS/2; p++) begin
				stage2[p] <= S2_W'(stage1[2*p]) + S2_W'(stage1[2*p+1]); // 8 to 4
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stage3 <= '0;
		end else begin
			for (int p = 0; p < GROUPS/4; p++) begin
				stage3[p] <= S3_W'(stage2[2*p]) + S3_W'(stage2[2*p+1]); // 4 to 2
			end
		end
	end

	// Final pair lands in the full row sum width
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sum <= '0;
		end else begin
			sum <= rowSumT'(stage3[0]) + rowSumT'(stage3[1]);
		end
	end

	// Valid follows the data through the same four registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			validPipe <= '0;
		end else begin
			validPipe <= {validPipe[2:0], valid};
		end
	end

	assign sumValid = validPipe[3];

endmodule

`default_nettype wire

/* src/splitRouting.sv */
`timescale 1ns/1ns
`default_nettype none

module splitRouting import adderPkg::*; #(
	parameter int COL_INDEX = 0
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       valid,
	input  convCfgT    cfg,
	input  rowSumT     row1,
	input  rowSumT     row2,
	input  rowSumT     row3,
	output logic       outValid,
	output psumHalvesT halves
);

	// Position of this column inside the 3x3 and 5x5 window groups
	localparam int NO3 = COL_INDEX % 8;
	localparam int NO5 = (COL_INDEX / 4) % 4;
	localparam int ID5 = COL_INDEX % 4;

	// Fixed per column, so the window decode below reduces to a few gates
	localparam bit SPLIT3_ROW1 = (NO3 == 7);
	localparam bit SPLIT3_ROW3 = (NO3 == 6);
	localparam bit SPLIT5_ROW1 = ((NO5 == 0) && (ID5 == 2 || ID5 == 3)) ||
	                             ((NO5 == 3) && (ID5 == 0 || ID5 == 1));
	localparam bit SPLIT5_ROW3 = (NO5 == 2) && (ID5 == 0 || ID5 == 1);

	halfSumT    ext1;
	halfSumT    ext2;
	halfSumT    ext3;
	logic       frontRow1; // Row 1 goes to the front half
	logic       frontRow3; // Row 3 goes to the front half
	psumHalvesT nextHalves;

	assign ext1 = halfSumT'(row1);
	assign ext2 = halfSumT'(row2);
	assign ext3 = halfSumT'(row3);

	always_comb begin
		frontRow1 = 1'b0;
		frontRow3 = 1'b0;
		case (cfg.winSize)
			WIN3X3: begin
				frontRow1 = SPLIT3_ROW1;
				frontRow3 = SPLIT3_ROW3;
			end
			WIN5X5: begin
				// Round 0 never splits
				if (cfg.winRound) begin
					frontRow1 = SPLIT5_ROW1;
					frontRow3 = SPLIT5_ROW3;
				end
			end
		endcase
	end

	always_comb begin
		if (frontRow1) begin
			nextHalves.front = ext1;
			nextHalves.back  = ext2 + ext3;
		end else if (frontRow3) begin
			nextHalves.front = ext3;
			nextHalves.back  = ext1 + ext2;
		end else begin
			nextHalves.front = '0;
			nextHalves.back  = ext1 + ext2 + ext3; // Whole window fits in this column
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			halves <= '0;
		end else if (valid) begin
			halves <= nextHalves; // Holds the last result between beats
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			outValid <= 1'b0;
		end else begin
			outValid <= valid;
		end
	end

endmodule

`default_nettype wire

/* src/columnSplitSum.sv */
`timescale 1ns/1ns
`default_nettype none

module columnSplitSum import adderPkg::*; #(
	parameter int COL_INDEX = 0
) (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           valid,
	input  convCfgT        cfg,
	input  columnProductsT products,
	output logic           outValid,
	output psumHalvesT     halves
);

	rowSumT        row1Sum;
	rowSumT        row2Sum;
	rowSumT        row3Sum;
	logic          treeValid;
	convCfgT [3:0] cfgPipe;

	// All three trees run in lockstep, so one valid serves the whole column
	rowReduceTree row1Tree_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.valid    (valid),
		.row      (products[0]),
		.sumValid (treeValid),
		.sum      (row1Sum)
	);

	rowReduceTree row2Tree_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.valid    (valid),
		.row      (products[1]),
		.sumValid (),
		.sum      (row2Sum)
	);

	rowReduceTree row3Tree_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.valid    (valid),
		.row      (products[2]),
		.sumValid (),
		.sum      (row3Sum)
	);

	// Same depth as the trees so each beat keeps its own window setting
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfgPipe <= '0;
		end else begin
			cfgPipe <= {cfgPipe[2:0], cfg};
		end
	end

	splitRouting #(
		.COL_INDEX (COL_INDEX)
	) routing_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.valid    (treeValid),
		.cfg      (cfgPipe[3]),
		.row1     (row1Sum),
		.row2     (row2Sum),
		.row3     (row3Sum),
		.outValid (outValid),
		.halves   (halves)
	);

endmodule

`default_nettype wire

/* src/partialSumArray.sv */
`timescale 1ns/1ns
`default_nettype none

module partialSumArray import adderPkg::*; #(
	parameter int COLUMNS = 16
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        inValid,
	input  convCfgT                     inCfg,
	input  columnProductsT [COLUMNS-1:0] products,
	output logic                        outValid,
	output psumHalvesT [COLUMNS-1:0]     psum
);

	logic [COLUMNS-1:0] colValid;

	// Each column learns its place in the window groups from its index
	for (genvar c = 0; c < COLUMNS; c++) begin : colGen
		columnSplitSum #(
			.COL_INDEX (c)
		) column_i (
			.clk      (clk),
			.rst_n    (rst_n),
			.valid    (inValid),
			.cfg      (inCfg),
			.products (products[c]),
			.outValid (colValid[c]),
			.halves   (psum[c])
		);
	end

	assign outValid = colValid[0]; // Columns share timing, any one of them would do

endmodule

`default_nettype wire

/* verif/psumChecker.sv */
`timescale 1ns/1ns
`default_nettype none

module psumChecker import adderPkg::*; #(
	parameter int COLUMNS = 16
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         inValid,
	input  convCfgT                      inCfg,
	input  columnProductsT [COLUMNS-1:0] products,
	input  logic                         outValid,
	input  psumHalvesT [COLUMNS-1:0]     psum,
	input  logic                         endCheck,
	output int                           mismatchCount,
	output int                           otherCount
);

	localparam int LATENCY = 5; // Edges from a sampled inValid to the sampled outValid

	typedef psumHalvesT [COLUMNS-1:0] arrayHalvesT;

	arrayHalvesT expQ[$];
	int          stampQ[$];
	int          cycleCount = 0;
	int          mismatches = 0;
	int          others = 0;
	bit          endDone = 1'b0;

	assign mismatchCount = mismatches;
	assign otherCount    = others;

	// Expected halves of one column, straight from the routing rule
	function automatic psumHalvesT expectedHalves(input convCfgT cfg, input int col,
		input columnProductsT p);
		halfSumT    r1;
		halfSumT    r2;
		halfSumT    r3;
		int         no3;
		int         no5;
		int         id5;
		psumHalvesT res;
		r1 = '0;
		r2 = '0;
		r3 = '0;
		for (int t = 0; t < ROW_TAPS; t++) begin
			r1 += halfSumT'(p[0][t]);
			r2 += halfSumT'(p[1][t]);
			r3 += halfSumT'(p[2][t]);
		end
		no3 = col % 8;
		no5 = (col / 4) % 4;
		id5 = col % 4;
		res.front = '0;
		res.back  = r1 + r2 + r3;
		if (cfg.winSize == WIN3X3) begin
			if (no3 == 6) begin
				res.front = r3;
				res.back  = r1 + r2;
			end else if (no3 == 7) begin
				res.front = r1;
				res.back  = r2 + r3;
			end
		end else if (cfg.winRound) begin
			if ((no5 == 0 && id5 >= 2) || (no5 == 3 && id5 <= 1)) begin
				res.front = r1;
				res.back  = r2 + r3;
			end else if (no5 == 2 && id5 <= 1) begin
				res.front = r3;
				res.back  = r1 + r2;
			end
		end
		return res;
	endfunction

	always @(posedge clk) begin : sampleBlock
		arrayHalvesT expected;
		arrayHalvesT fresh;
		int          stamp;
		if (!rst_n) begin
			if (outValid) begin
				others++;
				$display("ERROR at %0t ns: outValid is high during reset", $time);
			end
		end else begin
			cycleCount++;
			if (outValid) begin
				if (expQ.size() == 0) begin
					others++;
					$display("ERROR at %0t ns: outValid is high with no beat in flight", $time);
				end else begin
					expected = expQ.pop_front();
					stamp = stampQ.pop_front();
					if (cycleCount != stamp + LATENCY) begin
						others++;
						$display("ERROR at %0t ns: result came %0d cycles after its beat, not %0d",
							$time, cycleCount - stamp, LATENCY);
					end
					for (int c = 0; c < COLUMNS; c++) begin
						if (psum[c] !== expected[c]) begin
							mismatches++;
							$display("MISMATCH at %0t ns: col %0d front/back %h/%h, expected %h/%h",
								$time, c, psum[c].front, psum[c].back,
								expected[c].front, expected[c].back);
						end
					end
				end
			end
			if (inValid) begin
				for (int c = 0; c < COLUMNS; c++) begin
					fresh[c] = expectedHalves(inCfg, c, products[c]);
				end
				expQ.push_back(fresh);
				stampQ.push_back(cycleCount);
			end
			if (endCheck && !endDone) begin
				endDone = 1'b1;
				if (expQ.size() != 0) begin
					others++;
					$display("ERROR at %0t ns: %0d beats never came out", $time, expQ.size());
				end
			end
		end
	end

endmodule

`default_nettype wire

/* verif/tbPartialSum.sv */
`timescale 1ns/1ns
`default_nettype none

module tbPartialSum import adderPkg::*; ();

	localparam int COLUMNS      = 16;
	localparam int CLK_PERIOD   = 20;
	localparam int DRIVE_DELAY  = 2;
	localparam int RESET_CYCLES = 10;
	localparam int IDLE_CYCLES  = 20;
	localparam int PHASE_BEATS  = 32;
	localparam int MIXED_BEATS  = 64;
	localparam int MAX_GAP      = 3;
	localparam int ONES_BEATS   = 16;
	localparam int LATENCY      = 5; // Cycles from a beat to its result
	localparam int TOTAL_CYCLES = RESET_CYCLES + IDLE_CYCLES + 3 * PHASE_BEATS +
	                              MIXED_BEATS * (MAX_GAP + 1) + ONES_BEATS;
	localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 100) * CLK_PERIOD;

	logic                         clk = 1'b0;
	logic                         rst_n;
	logic                         inValid;
	convCfgT                      inCfg;
	columnProductsT [COLUMNS-1:0] products;
	logic                         outValid;
	psumHalvesT [COLUMNS-1:0]     psum;
	logic                         endCheck;
	int                           mismatchCount;
	int                           otherCount;
	logic [31:0]                  lfsr;

	always #(CLK_PERIOD / 2) clk = ~clk;

	partialSumArray #(
		.COLUMNS (COLUMNS)
	) partialSumArray_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.inValid  (inValid),
		.inCfg    (inCfg),
		.products (products),
		.outValid (outValid),
		.psum     (psum)
	);

	psumChecker #(
		.COLUMNS (COLUMNS)
	) checker_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.inValid       (inValid),
		.inCfg         (inCfg),
		.products      (products),
		.outValid      (outValid),
		.psum          (psum),
		.endCheck      (endCheck),
		.mismatchCount (mismatchCount),
		.otherCount    (otherCount)
	);

	// Taps 32, 22, 2 and 1 give a maximal length sequence
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic takeBits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrNext(lfsr);
			bits = {bits[30:0], lfsr[0]};
		end
	endtask

	task automatic driveBeat(input convCfgT cfg, input bit allOnes);
		columnProductsT [COLUMNS-1:0] beat;
		logic [31:0]                  bits;
		for (int c = 0; c < COLUMNS; c++) begin
			for (int r = 0; r < 3; r++) begin
				for (int t = 0; t < ROW_TAPS; t++) begin
					if (allOnes) begin
						beat[c][r][t] = '1;
					end else begin
						takeBits(PRODUCT_W, bits);
						beat[c][r][t] = bits[PRODUCT_W-1:0];
					end
				end
			end
		end
		@(posedge clk);
		#DRIVE_DELAY;
		inValid  = 1'b1;
		inCfg    = cfg;
		products = beat;
	endtask

	task automatic driveIdle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			#DRIVE_DELAY;
			inValid = 1'b0;
		end
	endtask

	initial begin
		#WATCHDOG_NS;
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

	initial begin : mainFlow
		convCfgT     cfg;
		logic [31:0] bits;
		lfsr     = 32'h610a_1e0a;
		rst_n    = 1'b0;
		inValid  = 1'b0;
		inCfg    = '0;
		products = '0;
		endCheck = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;

		driveIdle(IDLE_CYCLES); // Nothing may come out without input

		for (int i = 0; i < PHASE_BEATS; i++) begin
			takeBits(1, bits);
			cfg.winSize  = WIN3X3;
			cfg.winRound = bits[0]; // Round has no meaning for 3x3
			driveBeat(cfg, 1'b0);
		end
		for (int i = 0; i < PHASE_BEATS; i++) begin
			cfg.winSize  = WIN5X5;
			cfg.winRound = 1'b0;
			driveBeat(cfg, 1'b0);
		end
		for (int i = 0; i < PHASE_BEATS; i++) begin
			cfg.winSize  = WIN5X5;
			cfg.winRound = 1'b1;
			driveBeat(cfg, 1'b0);
		end

		// Config changes from beat to beat with idle gaps between
		for (int i = 0; i < MIXED_BEATS; i++) begin
			takeBits(2, bits);
			cfg = convCfgT'(bits[1:0]);
			driveBeat(cfg, 1'b0);
			takeBits(2, bits);
			driveIdle(int'(bits[1:0]));
		end

		for (int i = 0; i < ONES_BEATS; i++) begin
			cfg = convCfgT'(2'(i % 4));
			driveBeat(cfg, 1'b1);
		end

		driveIdle(LATENCY); // The last result is due on the edge that sees endCheck
		endCheck = 1'b1;
		driveIdle(1);

		$display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
		if (mismatchCount == 0 && otherCount == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
src/adderPkg.sv
src/rowReduceTree.sv
src/splitRouting.sv
src/columnSplitSum.sv
src/partialSumArray.sv
verif/psumChecker.sv
verif/tbPartialSum.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the partial sum array testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tbPartialSum -f files.f

./obj_dir/VtbPartialSum | tee "$LOG"

if grep -qx "Test completed successfully" "$LOG"; then
	echo "Simulation passed"
else
	echo "Simulation failed, see $LOG"
	exit 1
fi
